//--- dispatch_defs.svh
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

`define DATA_W  32
`define REG_NUM 32
`define REG_AW  5
`define ALU_W   8

// Loads. Any of these in execute can cause a load-use stall.
`define ALU_LDB       8'h20
`define ALU_LDH       8'h21
`define ALU_LDW       8'h22
`define ALU_LDBU      8'h23
`define ALU_LDHU      8'h24
`define ALU_LLW       8'h25
`define ALU_SCW       8'h26

`define ALU_BEQ       8'h40
`define ALU_BNE       8'h41
`define ALU_BLT       8'h42
`define ALU_BGE       8'h43
`define ALU_BLTU      8'h44
`define ALU_BGEU      8'h45
`define ALU_B         8'h46
`define ALU_BL        8'h47
`define ALU_JIRL      8'h48

`define ALU_PCADDU12I 8'h10
`define ALU_ADD       8'h01

`endif

//--- isa_pkg.sv
`include "dispatch_defs.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0] bus32_t;

    typedef logic [`ALU_W-1:0] alu_op_t;

    // Layout used by the 16-bit offset branches and JIRL.
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] off16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_off16_t;

    // Layout used by B and BL, the offset is split across two fields.
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] off_lo;
        logic [9:0]  off_hi;
    } inst_off26_t;

    typedef union packed {
        inst_off16_t f16;
        inst_off26_t f26;
    } inst_u;

endpackage

//--- pipe_pkg.sv
`include "dispatch_defs.svh"

package pipe_pkg;

    typedef struct packed {
        logic               en;
        logic [`REG_AW-1:0] addr;
        isa_pkg::bus32_t    data;
    } fwd_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::bus32_t    pc;
        isa_pkg::alu_op_t   aluop;
        isa_pkg::bus32_t    reg1;
        isa_pkg::bus32_t    reg2;
        isa_pkg::bus32_t    link_data;
        logic               reg_write_en;
        logic [`REG_AW-1:0] reg_write_addr;
    } dispatch_ex_t;

    typedef struct packed {
        logic            en;
        logic            taken;
        logic            flush;
        isa_pkg::bus32_t target;
    } branch_upd_t;

endpackage

//--- operand_if.sv
`include "dispatch_defs.svh"
`timescale 1ns/1ps

interface operand_if;
    import isa_pkg::*;

    logic               read_en;
    logic [`REG_AW-1:0] read_addr;
    bus32_t             imm;
    logic               use_pc;
    bus32_t             pc;
    bus32_t             value;
    logic               hazard;

    modport req (output read_en, read_addr, imm, use_pc, pc);

    modport unit (input read_en, read_addr, imm, use_pc, pc, output value, hazard);

    modport sink (input value, hazard);

endinterface

//--- regfile.sv
`include "dispatch_defs.svh"
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rd0_en,
    input  logic [`REG_AW-1:0] rd0_addr,
    output isa_pkg::bus32_t    rd0_data,
    input  logic               rd1_en,
    input  logic [`REG_AW-1:0] rd1_addr,
    output isa_pkg::bus32_t    rd1_data,
    input  logic               wb_en,
    input  logic [`REG_AW-1:0] wb_addr,
    input  isa_pkg::bus32_t    wb_data
);
    import isa_pkg::*;

    bus32_t regs [`REG_NUM];
    logic   wb_live;

    assign wb_live = wb_en && (wb_addr != '0); // Writes to r0 are dropped.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[wb_addr] <= wb_data;
        end
    end

    assign rd0_data = (!rd0_en || rd0_addr == '0) ? '0 :
                      (wb_live && wb_addr == rd0_addr) ? wb_data : regs[rd0_addr];
    assign rd1_data = (!rd1_en || rd1_addr == '0) ? '0 :
                      (wb_live && wb_addr == rd1_addr) ? wb_data : regs[rd1_addr];

    a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n) regs[0] == '0);

endmodule

//--- dispatch_decode.sv
`include "dispatch_defs.svh"
`timescale 1ns/1ps

module dispatch_decode (
    input  isa_pkg::bus32_t    id_pc,
    input  isa_pkg::inst_u     id_inst,
    input  isa_pkg::alu_op_t   id_aluop,
    input  logic               id_reg1_read_en,
    input  logic [`REG_AW-1:0] id_reg1_read_addr,
    input  logic               id_reg2_read_en,
    input  logic [`REG_AW-1:0] id_reg2_read_addr,
    input  isa_pkg::bus32_t    id_imm,
    input  isa_pkg::alu_op_t   ex_aluop,
    operand_if.req             op0,
    operand_if.req             op1,
    output logic               ex_is_load,
    output isa_pkg::bus32_t    off16_ext,
    output isa_pkg::bus32_t    off26_ext
);
    import isa_pkg::*;

    assign op0.read_en   = id_reg1_read_en;
    assign op0.read_addr = id_reg1_read_addr;
    assign op0.imm       = id_imm;
    assign op0.use_pc    = (id_aluop == `ALU_PCADDU12I); // Only PCADDU12I takes pc as its operand.
    assign op0.pc        = id_pc;

    assign op1.read_en   = id_reg2_read_en;
    assign op1.read_addr = id_reg2_read_addr;
    assign op1.imm       = id_imm;
    assign op1.use_pc    = 1'b0;
    assign op1.pc        = id_pc;

    always_comb begin
        case (ex_aluop)
            `ALU_LDB, `ALU_LDH, `ALU_LDW, `ALU_LDBU,
            `ALU_LDHU, `ALU_LLW, `ALU_SCW: ex_is_load = 1'b1;
            default:                       ex_is_load = 1'b0;
        endcase
    end

    // Word offsets, shifted to byte addresses.
    assign off16_ext = {{14{id_inst.f16.off16[15]}}, id_inst.f16.off16, 2'b00};
    assign off26_ext = {{4{id_inst.f26.off_hi[9]}}, id_inst.f26.off_hi,
                        id_inst.f26.off_lo, 2'b00}; // High part sits in the low bits.

endmodule

//--- operand_fwd.sv
`include "dispatch_defs.svh"
`timescale 1ns/1ps

module operand_fwd (
    operand_if.unit         opnd,
    input  pipe_pkg::fwd_t  ex_fwd,
    input  pipe_pkg::fwd_t  mem_fwd,
    input  logic            ex_is_load,
    input  logic            pause,
    input  isa_pkg::bus32_t rf_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic src_live;
    logic ex_hit;
    logic mem_hit;

    assign src_live = opnd.read_en && (opnd.read_addr != '0); // r0 never forwards.
    assign ex_hit   = src_live && ex_fwd.en && (ex_fwd.addr == opnd.read_addr);
    assign mem_hit  = src_live && mem_fwd.en && (mem_fwd.addr == opnd.read_addr);

    // The load result is not ready until memory, so the stage must wait a cycle.
    assign opnd.hazard = ex_is_load && src_live && (ex_fwd.addr == opnd.read_addr);

    always_comb begin
        if (pause) begin
            opnd.value = '0;
        end else if (opnd.use_pc) begin
            opnd.value = opnd.pc;
        end else if (ex_hit) begin
            opnd.value = ex_fwd.data; // Youngest result wins.
        end else if (mem_hit) begin
            opnd.value = mem_fwd.data;
        end else if (opnd.read_en) begin
            opnd.value = rf_data;
        end else begin
            opnd.value = opnd.imm;
        end
    end

endmodule

//--- branch_resolve.sv
`include "dispatch_defs.svh"
`timescale 1ns/1ps

module branch_resolve (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   id_valid,
    input  isa_pkg::bus32_t        id_pc,
    input  isa_pkg::alu_op_t       id_aluop,
    input  logic                   id_reg_write_en,
    input  logic [`REG_AW-1:0]     id_reg_write_addr,
    input  logic                   id_pre_taken,
    input  isa_pkg::bus32_t        id_pre_target,
    input  isa_pkg::bus32_t        off16_ext,
    input  isa_pkg::bus32_t        off26_ext,
    operand_if.sink                op0,
    operand_if.sink                op1,
    output logic                   pause,
    output pipe_pkg::branch_upd_t  upd,
    output pipe_pkg::dispatch_ex_t ex_out
);
    import isa_pkg::*;
    import pipe_pkg::*;

    bus32_t       reg1;
    bus32_t       reg2;
    bus32_t       pc_plus4;
    bus32_t       target;
    bus32_t       link_data;
    logic         is_taken;
    logic         issue;
    dispatch_ex_t ex_next;
    dispatch_ex_t ex_q;

    assign pause    = op0.hazard | op1.hazard;
    assign issue    = id_valid & ~pause;
    assign reg1     = op0.value;
    assign reg2     = op1.value;
    assign pc_plus4 = id_pc + 32'd4;

    always_comb begin
        is_taken  = 1'b0;
        target    = id_pc + off16_ext;
        link_data = '0;
        case (id_aluop)
            `ALU_BEQ:  is_taken = (reg1 == reg2);
            `ALU_BNE:  is_taken = (reg1 != reg2);
            `ALU_BLT:  is_taken = ($signed(reg1) < $signed(reg2));
            `ALU_BGE:  is_taken = ($signed(reg1) >= $signed(reg2));
            `ALU_BLTU: is_taken = (reg1 < reg2);
            `ALU_BGEU: is_taken = (reg1 >= reg2);
            `ALU_B: begin
                is_taken = 1'b1;
                target   = id_pc + off26_ext;
            end
            `ALU_BL: begin
                is_taken  = 1'b1;
                target    = id_pc + off26_ext;
                link_data = pc_plus4;
            end
            `ALU_JIRL: begin
                is_taken  = 1'b1;
                target    = reg1 + off16_ext; // Register-relative jump.
                link_data = pc_plus4;
            end
            default: ;
        endcase
    end

    always_comb begin
        upd = '0;
        if (issue) begin
            upd.en    = 1'b1;
            upd.taken = is_taken;
            if (is_taken && !(id_pre_taken && (id_pre_target == target))) begin
                upd.flush  = 1'b1;
                upd.target = target;
            end else if (!is_taken && id_pre_taken) begin
                upd.flush  = 1'b1;
                upd.target = pc_plus4; // Undo a wrong taken guess.
            end
        end
    end

    always_comb begin
        ex_next = '0; // A paused or idle cycle sends an all-zero bubble.
        if (issue) begin
            ex_next.valid          = 1'b1;
            ex_next.pc             = id_pc;
            ex_next.aluop          = id_aluop;
            ex_next.reg1           = reg1;
            ex_next.reg2           = reg2;
            ex_next.link_data      = link_data;
            ex_next.reg_write_en   = id_reg_write_en;
            ex_next.reg_write_addr = id_reg_write_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_next;
        end
    end

    assign ex_out = ex_q;

    a_flush_has_en: assert property (@(posedge clk) disable iff (!arst_n) upd.flush |-> upd.en);

endmodule

//--- dispatch_top.sv
`include "dispatch_defs.svh"
`timescale 1ns/1ps

module dispatch_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               id_valid,
    input  isa_pkg::bus32_t    id_pc,
    input  isa_pkg::inst_u     id_inst,
    input  isa_pkg::alu_op_t   id_aluop,
    input  logic               id_reg1_read_en,
    input  logic [`REG_AW-1:0] id_reg1_read_addr,
    input  logic               id_reg2_read_en,
    input  logic [`REG_AW-1:0] id_reg2_read_addr,
    input  isa_pkg::bus32_t    id_imm,
    input  logic               id_reg_write_en,
    input  logic [`REG_AW-1:0] id_reg_write_addr,
    input  logic               id_pre_taken,
    input  isa_pkg::bus32_t    id_pre_target,
    input  isa_pkg::alu_op_t   ex_aluop,
    input  logic               ex_fwd_en,
    input  logic [`REG_AW-1:0] ex_fwd_addr,
    input  isa_pkg::bus32_t    ex_fwd_data,
    input  logic               mem_fwd_en,
    input  logic [`REG_AW-1:0] mem_fwd_addr,
    input  isa_pkg::bus32_t    mem_fwd_data,
    input  logic               wb_en,
    input  logic [`REG_AW-1:0] wb_addr,
    input  isa_pkg::bus32_t    wb_data,
    output logic               pause,
    output logic               ex_valid,
    output isa_pkg::bus32_t    ex_pc,
    output isa_pkg::alu_op_t   ex_aluop_out,
    output isa_pkg::bus32_t    ex_reg1,
    output isa_pkg::bus32_t    ex_reg2,
    output isa_pkg::bus32_t    ex_link_data,
    output logic               ex_reg_write_en,
    output logic [`REG_AW-1:0] ex_reg_write_addr,
    output logic               upd_en,
    output logic               upd_taken,
    output logic               upd_flush,
    output isa_pkg::bus32_t    upd_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fwd_t         ex_fwd;
    fwd_t         mem_fwd;
    bus32_t       rf_data [2];
    bus32_t       off16_ext;
    bus32_t       off26_ext;
    logic         ex_is_load;
    branch_upd_t  upd;
    dispatch_ex_t ex_out;

    operand_if opnd [2] ();

    assign ex_fwd.en    = ex_fwd_en;
    assign ex_fwd.addr  = ex_fwd_addr;
    assign ex_fwd.data  = ex_fwd_data;
    assign mem_fwd.en   = mem_fwd_en;
    assign mem_fwd.addr = mem_fwd_addr;
    assign mem_fwd.data = mem_fwd_data;

    regfile i_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd0_en   (id_reg1_read_en),
        .rd0_addr (id_reg1_read_addr),
        .rd0_data (rf_data[0]),
        .rd1_en   (id_reg2_read_en),
        .rd1_addr (id_reg2_read_addr),
        .rd1_data (rf_data[1]),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    dispatch_decode i_dispatch_decode (
        .id_pc             (id_pc),
        .id_inst           (id_inst),
        .id_aluop          (id_aluop),
        .id_reg1_read_en   (id_reg1_read_en),
        .id_reg1_read_addr (id_reg1_read_addr),
        .id_reg2_read_en   (id_reg2_read_en),
        .id_reg2_read_addr (id_reg2_read_addr),
        .id_imm            (id_imm),
        .ex_aluop          (ex_aluop),
        .op0               (opnd[0]),
        .op1               (opnd[1]),
        .ex_is_load        (ex_is_load),
        .off16_ext         (off16_ext),
        .off26_ext         (off26_ext)
    );

    for (genvar g = 0; g < 2; g++) begin : g_opnd
        operand_fwd i_operand_fwd (
            .opnd       (opnd[g]),
            .ex_fwd     (ex_fwd),
            .mem_fwd    (mem_fwd),
            .ex_is_load (ex_is_load),
            .pause      (pause),
            .rf_data    (rf_data[g])
        );
    end

    branch_resolve i_branch_resolve (
        .clk               (clk),
        .arst_n            (arst_n),
        .id_valid          (id_valid),
        .id_pc             (id_pc),
        .id_aluop          (id_aluop),
        .id_reg_write_en   (id_reg_write_en),
        .id_reg_write_addr (id_reg_write_addr),
        .id_pre_taken      (id_pre_taken),
        .id_pre_target     (id_pre_target),
        .off16_ext         (off16_ext),
        .off26_ext         (off26_ext),
        .op0               (opnd[0]),
        .op1               (opnd[1]),
        .pause             (pause),
        .upd               (upd),
        .ex_out            (ex_out)
    );

    assign ex_valid          = ex_out.valid;
    assign ex_pc             = ex_out.pc;
    assign ex_aluop_out      = ex_out.aluop;
    assign ex_reg1           = ex_out.reg1;
    assign ex_reg2           = ex_out.reg2;
    assign ex_link_data      = ex_out.link_data;
    assign ex_reg_write_en   = ex_out.reg_write_en;
    assign ex_reg_write_addr = ex_out.reg_write_addr;

    assign upd_en     = upd.en;
    assign upd_taken  = upd.taken;
    assign upd_flush  = upd.flush;
    assign upd_target = upd.target;

endmodule

//--- tb_dispatch_top.sv
`include "dispatch_defs.svh"
`timescale 1ns/1ps

module tb_dispatch_top;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_TXN        = 2000;
    localparam int TIMEOUT_CYCLES = 2 * NUM_TXN; // Twice the transaction count covers reset and idle.

    logic               clk;
    logic               arst_n;
    logic               id_valid;
    bus32_t             id_pc;
    inst_u              id_inst;
    alu_op_t            id_aluop;
    logic               id_reg1_read_en;
    logic [`REG_AW-1:0] id_reg1_read_addr;
    logic               id_reg2_read_en;
    logic [`REG_AW-1:0] id_reg2_read_addr;
    bus32_t             id_imm;
    logic               id_reg_write_en;
    logic [`REG_AW-1:0] id_reg_write_addr;
    logic               id_pre_taken;
    bus32_t             id_pre_target;
    alu_op_t            ex_aluop;
    logic               ex_fwd_en;
    logic [`REG_AW-1:0] ex_fwd_addr;
    bus32_t             ex_fwd_data;
    logic               mem_fwd_en;
    logic [`REG_AW-1:0] mem_fwd_addr;
    bus32_t             mem_fwd_data;
    logic               wb_en;
    logic [`REG_AW-1:0] wb_addr;
    bus32_t             wb_data;
    logic               pause;
    logic               ex_valid;
    bus32_t             ex_pc;
    alu_op_t            ex_aluop_out;
    bus32_t             ex_reg1;
    bus32_t             ex_reg2;
    bus32_t             ex_link_data;
    logic               ex_reg_write_en;
    logic [`REG_AW-1:0] ex_reg_write_addr;
    logic               upd_en;
    logic               upd_taken;
    logic               upd_flush;
    bus32_t             upd_target;

    bus32_t       model_regs [`REG_NUM];
    logic         exp_pause;
    branch_upd_t  exp_upd;
    dispatch_ex_t exp_ex_next;
    dispatch_ex_t exp_ex_prev;
    int           cycle_cnt;

    dispatch_top i_dispatch_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail %s: got %h expected %h", name, act, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_upd(input branch_upd_t act, input branch_upd_t exp);
        if (act !== exp) begin
            $display("Fail upd: got %h expected %h", act, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on the branch update");
        end
    endtask

    task automatic check_ex(input dispatch_ex_t act, input dispatch_ex_t exp);
        if (act !== exp) begin
            $display("Fail ex_out: got %h expected %h", act, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on the execute bundle");
        end
    endtask

    function automatic branch_upd_t sample_upd();
        branch_upd_t u;
        u.en     = upd_en;
        u.taken  = upd_taken;
        u.flush  = upd_flush;
        u.target = upd_target;
        return u;
    endfunction

    function automatic dispatch_ex_t sample_ex();
        dispatch_ex_t e;
        e.valid          = ex_valid;
        e.pc             = ex_pc;
        e.aluop          = ex_aluop_out;
        e.reg1           = ex_reg1;
        e.reg2           = ex_reg2;
        e.link_data      = ex_link_data;
        e.reg_write_en   = ex_reg_write_en;
        e.reg_write_addr = ex_reg_write_addr;
        return e;
    endfunction

    // Values cluster near zero and the sign boundary so compares hit both ways.
    function automatic bus32_t rand_data();
        case ($urandom_range(0, 3))
            0:       return 32'($urandom_range(0, 3));
            1:       return 32'h8000_0000 | 32'($urandom_range(0, 3));
            2:       return 32'hFFFF_FFFF;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [`REG_AW-1:0] rand_addr();
        return 5'($urandom_range(0, 5)); // Few registers, so matches are common.
    endfunction

    function automatic alu_op_t pick_id_op();
        case ($urandom_range(0, 10))
            0:       return `ALU_ADD;
            1:       return `ALU_PCADDU12I;
            2:       return `ALU_BEQ;
            3:       return `ALU_BNE;
            4:       return `ALU_BLT;
            5:       return `ALU_BGE;
            6:       return `ALU_BLTU;
            7:       return `ALU_BGEU;
            8:       return `ALU_B;
            9:       return `ALU_BL;
            default: return `ALU_JIRL;
        endcase
    endfunction

    function automatic alu_op_t pick_ex_op();
        case ($urandom_range(0, 10))
            0:       return `ALU_LDB;
            1:       return `ALU_LDH;
            2:       return `ALU_LDW;
            3:       return `ALU_LDBU;
            4:       return `ALU_LDHU;
            5:       return `ALU_LLW;
            6:       return `ALU_SCW;
            default: return `ALU_ADD;
        endcase
    endfunction

    function automatic logic is_load(input alu_op_t op);
        return op inside {`ALU_LDB, `ALU_LDH, `ALU_LDW, `ALU_LDBU,
                          `ALU_LDHU, `ALU_LLW, `ALU_SCW};
    endfunction

    function automatic bus32_t model_read(input logic [`REG_AW-1:0] addr);
        if (addr == '0) return '0;
        if (wb_en && wb_addr == addr) return wb_data; // Same-cycle write shows through.
        return model_regs[addr];
    endfunction

    function automatic bus32_t model_operand(input logic hold, input logic take_pc,
                                             input logic rd_en, input logic [`REG_AW-1:0] addr);
        logic live;
        live = rd_en && (addr != '0);
        if (hold) return '0;
        if (take_pc) return id_pc;
        if (live && ex_fwd_en && ex_fwd_addr == addr) return ex_fwd_data;
        if (live && mem_fwd_en && mem_fwd_addr == addr) return mem_fwd_data;
        if (rd_en) return model_read(addr);
        return id_imm;
    endfunction

    task automatic idle_inputs();
        id_valid          = 1'b0;
        id_pc             = '0;
        id_inst           = '0;
        id_aluop          = '0;
        id_reg1_read_en   = 1'b0;
        id_reg1_read_addr = '0;
        id_reg2_read_en   = 1'b0;
        id_reg2_read_addr = '0;
        id_imm            = '0;
        id_reg_write_en   = 1'b0;
        id_reg_write_addr = '0;
        id_pre_taken      = 1'b0;
        id_pre_target     = '0;
        ex_aluop          = '0;
        ex_fwd_en         = 1'b0;
        ex_fwd_addr       = '0;
        ex_fwd_data       = '0;
        mem_fwd_en        = 1'b0;
        mem_fwd_addr      = '0;
        mem_fwd_data      = '0;
        wb_en             = 1'b0;
        wb_addr           = '0;
        wb_data           = '0;
    endtask

    // Draws one transaction and works out what the stage must answer.
    task automatic drive_txn();
        bus32_t r1;
        bus32_t r2;
        bus32_t target;
        bus32_t pc4;
        bus32_t off16_x;
        bus32_t off26_x;
        logic   taken;
        logic   issue;
        id_valid          = ($urandom_range(0, 7) != 0);
        id_pc             = $urandom & 32'hFFFF_FFFC;
        id_inst           = $urandom;
        id_aluop          = pick_id_op();
        id_reg1_read_en   = 1'($urandom_range(0, 1));
        id_reg1_read_addr = rand_addr();
        id_reg2_read_en   = 1'($urandom_range(0, 1));
        id_reg2_read_addr = rand_addr();
        id_imm            = $urandom;
        id_reg_write_en   = 1'($urandom_range(0, 1));
        id_reg_write_addr = rand_addr();
        id_pre_taken      = 1'($urandom_range(0, 1));
        ex_aluop          = pick_ex_op();
        ex_fwd_en         = 1'($urandom_range(0, 1));
        ex_fwd_addr       = rand_addr();
        ex_fwd_data       = rand_data();
        mem_fwd_en        = 1'($urandom_range(0, 1));
        mem_fwd_addr      = rand_addr();
        mem_fwd_data      = rand_data();
        wb_en             = 1'($urandom_range(0, 1));
        wb_addr           = rand_addr();
        wb_data           = rand_data();

        exp_pause = is_load(ex_aluop) &&
                    ((id_reg1_read_en && id_reg1_read_addr != '0 &&
                      id_reg1_read_addr == ex_fwd_addr) ||
                     (id_reg2_read_en && id_reg2_read_addr != '0 &&
                      id_reg2_read_addr == ex_fwd_addr));
        issue = id_valid && !exp_pause;
        r1 = model_operand(exp_pause, id_aluop == `ALU_PCADDU12I,
                           id_reg1_read_en, id_reg1_read_addr);
        r2 = model_operand(exp_pause, 1'b0, id_reg2_read_en, id_reg2_read_addr);

        off16_x = {{14{id_inst[25]}}, id_inst[25:10], 2'b00};
        off26_x = {{4{id_inst[9]}}, id_inst[9:0], id_inst[25:10], 2'b00};
        pc4     = id_pc + 32'd4;
        taken   = 1'b0;
        target  = id_pc + off16_x;
        case (id_aluop)
            `ALU_BEQ:  taken = (r1 == r2);
            `ALU_BNE:  taken = (r1 != r2);
            `ALU_BLT:  taken = ($signed(r1) < $signed(r2));
            `ALU_BGE:  taken = ($signed(r1) >= $signed(r2));
            `ALU_BLTU: taken = (r1 < r2);
            `ALU_BGEU: taken = (r1 >= r2);
            `ALU_B, `ALU_BL: begin
                taken  = 1'b1;
                target = id_pc + off26_x;
            end
            `ALU_JIRL: begin
                taken  = 1'b1;
                target = r1 + off16_x;
            end
            default: ;
        endcase

        // Half the predictions name the right target, so all four cases show up.
        id_pre_target = ($urandom_range(0, 1) != 0) ? target : ($urandom & 32'hFFFF_FFFC);

        exp_upd = '0;
        if (issue) begin
            exp_upd.en    = 1'b1;
            exp_upd.taken = taken;
            if (taken && !(id_pre_taken && id_pre_target == target)) begin
                exp_upd.flush  = 1'b1;
                exp_upd.target = target;
            end else if (!taken && id_pre_taken) begin
                exp_upd.flush  = 1'b1;
                exp_upd.target = pc4;
            end
        end

        exp_ex_next = '0;
        if (issue) begin
            exp_ex_next.valid          = 1'b1;
            exp_ex_next.pc             = id_pc;
            exp_ex_next.aluop          = id_aluop;
            exp_ex_next.reg1           = r1;
            exp_ex_next.reg2           = r2;
            exp_ex_next.link_data      = (id_aluop == `ALU_BL || id_aluop == `ALU_JIRL) ? pc4 : '0;
            exp_ex_next.reg_write_en   = id_reg_write_en;
            exp_ex_next.reg_write_addr = id_reg_write_addr;
        end
    endtask

    initial begin
        void'($urandom(90));
        arst_n    = 1'b0;
        cycle_cnt = 0;
        idle_inputs();
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        exp_ex_prev = '0;

        // A valid writing transaction sits on the inputs while reset holds the bundle empty.
        id_valid          = 1'b1;
        id_reg_write_en   = 1'b1;
        id_reg_write_addr = 5'd3;

        repeat (5) begin
            @(posedge clk);
            #1;
            check_bit("ex_valid", ex_valid, 1'b0);
            check_bit("ex_reg_write_en", ex_reg_write_en, 1'b0);
        end
        idle_inputs();
        arst_n = 1'b1;

        repeat (3) begin
            @(posedge clk);
            #3;
            check_bit("ex_valid", ex_valid, 1'b0);
            check_bit("ex_reg_write_en", ex_reg_write_en, 1'b0);
        end

        for (int t = 0; t < NUM_TXN; t++) begin
            @(posedge clk);
            #1;
            drive_txn();
            #2;
            check_bit("pause", pause, exp_pause);
            check_upd(sample_upd(), exp_upd);
            check_ex(sample_ex(), exp_ex_prev); // Bundle registered from the previous transaction.
            exp_ex_prev = exp_ex_next;
            if (wb_en && wb_addr != '0) begin
                model_regs[wb_addr] = wb_data;
            end
        end

        @(posedge clk);
        #1;
        idle_inputs();
        #2;
        check_ex(sample_ex(), exp_ex_prev);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
operand_if.sv
regfile.sv
dispatch_decode.sv
operand_fwd.sv
branch_resolve.sv
dispatch_top.sv
tb_dispatch_top.sv

//--- Makefile
TOP := tb_dispatch_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
